// ==== hw/sd_pkg.sv ====
`default_nettype none

//====================================================================
// SD block host definitions
// Sector geometry and the byte, buffer index, sector number and
// image size types shared with the SD card host
//====================================================================

package sd_pkg;

	// Sector geometry
	localparam int SECTOR_BYTES = 512;
	localparam int SECTOR_SHIFT = $clog2(SECTOR_BYTES);

	// One byte of the host sector buffer
	typedef logic [7:0] sd_byte_t;

	// Byte index inside one sector
	typedef logic [SECTOR_SHIFT-1:0] sd_buf_addr_t;

	// Sector number on the card
	typedef logic [31:0] sd_lba_t;

	// Mounted image size in bytes
	typedef logic [31:0] sd_size_t;

endpackage

`default_nettype wire

// ==== hw/bk_pkg.sv ====
`default_nettype none

//====================================================================
// Backup engine definitions
// Save RAM geometry, word and address types, engine state
//====================================================================

package bk_pkg;

	// 4096 words of 16 bits, 8 KB, 16 sectors
	localparam int BK_WORD_ADDR_W = 12;
	localparam int BK_WORDS       = 1 << BK_WORD_ADDR_W;
	localparam int BK_MAX_SECTORS = 16;
	localparam int BK_SECTOR_W    = 5;

	typedef logic [15:0] bk_word_t;

	// Word port and console byte port addresses
	typedef logic [BK_WORD_ADDR_W-1:0] bk_word_addr_t;
	typedef logic [BK_WORD_ADDR_W:0]   bk_byte_addr_t;

	// Sector count inside save RAM
	typedef logic [BK_SECTOR_W-1:0] bk_sector_t;

	typedef enum logic {
		IDLE,
		XFER
	} bk_state_t;

endpackage

`default_nettype wire

// ==== hw/bk_control_fsm.sv ====
`default_nettype none

//====================================================================
// Backup engine control
// Mount and enable tracking, load and save sequencing, SD requests
//====================================================================

module bk_control_fsm (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               img_mounted,
	input  sd_pkg::sd_size_t   img_size,
	input  logic               cart_download,
	input  logic               save_req,
	input  logic               sd_ack,
	input  logic               last_sector,
	output logic               bk_ena,
	output logic               bk_busy,
	output logic               sd_rd,
	output logic               sd_wr,
	output logic               xfer_start,
	output logic               sector_step,
	output bk_pkg::bk_sector_t last_lba
);

	bk_pkg::bk_state_t state;
	sd_pkg::sd_size_t  size_m1;
	logic              load_pend;
	logic              xfer_load;
	logic              cart_d;
	logic              save_d;
	logic              ack_r;
	logic              ack_d;
	logic              cart_rise;
	logic              save_rise;
	logic              ack_rise;
	logic              ack_fall;

	// Last byte index of the image, its sector is the last one
	assign size_m1 = img_size - 1'b1;

	assign cart_rise = cart_download & ~cart_d;
	assign save_rise = save_req & ~save_d;
	assign ack_rise  = ack_r & ~ack_d;
	assign ack_fall  = ~ack_r & ack_d;

	// A pending load takes priority over a save edge
	assign xfer_start  = (state == bk_pkg::IDLE) && bk_ena && (load_pend || save_rise);
	assign sector_step = (state == bk_pkg::XFER) && ack_fall && !last_sector;
	assign bk_busy     = (state == bk_pkg::XFER);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= bk_pkg::IDLE;
			bk_ena    <= 1'b0;
			load_pend <= 1'b0;
			xfer_load <= 1'b0;
			sd_rd     <= 1'b0;
			sd_wr     <= 1'b0;
			last_lba  <= '0;
			cart_d    <= 1'b0;
			save_d    <= 1'b0;
			ack_r     <= 1'b0;
			ack_d     <= 1'b0;
		end else begin
			cart_d <= cart_download;
			save_d <= save_req;
			ack_r  <= sd_ack;
			ack_d  <= ack_r;

			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bk_pkg::IDLE: begin
					if (xfer_start) begin
						state     <= bk_pkg::XFER;
						xfer_load <= load_pend;
						load_pend <= 1'b0;
						sd_rd     <= load_pend;
						sd_wr     <= ~load_pend;
					end
				end
				bk_pkg::XFER: begin
					// Sector done, either finish or ask for the next one
					if (ack_fall) begin
						if (last_sector) begin
							state <= bk_pkg::IDLE;
						end else begin
							sd_rd <= xfer_load;
							sd_wr <= ~xfer_load;
						end
					end
				end
				default: state <= bk_pkg::IDLE;
			endcase

			// Mount and download events win over a start in the same cycle
			if (img_mounted) begin
				if (img_size != '0) begin
					bk_ena    <= 1'b1;
					load_pend <= 1'b1;
					last_lba  <= bk_pkg::bk_sector_t'(size_m1 >> sd_pkg::SECTOR_SHIFT);
				end else begin
					bk_ena    <= 1'b0;
					load_pend <= 1'b0;
				end
			end

			if (cart_rise) begin
				bk_ena    <= 1'b0;
				load_pend <= 1'b0;
			end
		end
	end

	a_req_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	// Image must fit in save RAM
	a_mount_fits: assert property (@(posedge clk_sys) disable iff (reset)
		img_mounted && (img_size != '0) |->
		(size_m1 >> sd_pkg::SECTOR_SHIFT) < bk_pkg::BK_MAX_SECTORS);

endmodule

`default_nettype wire

// ==== hw/bk_sector_counter.sv ====
`default_nettype none

//====================================================================
// Backup sector counter
// Current sector number of a transfer and last sector flag
//====================================================================

module bk_sector_counter (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               xfer_start,
	input  logic               sector_step,
	input  bk_pkg::bk_sector_t last_lba,
	output sd_pkg::sd_lba_t    sd_lba,
	output logic               last_sector
);

	bk_pkg::bk_sector_t sector;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sector <= '0;
		end else if (xfer_start) begin
			sector <= '0;
		end else if (sector_step) begin
			sector <= sector + 1'b1;
		end
	end

	assign sd_lba      = sd_pkg::sd_lba_t'(sector);
	assign last_sector = (sector == last_lba);

	// The FSM never steps past the final sector
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (reset)
		sector_step |-> sector < last_lba);

endmodule

`default_nettype wire

// ==== hw/bk_word_packer.sv ====
`default_nettype none

//====================================================================
// Backup byte/word packer
// Joins SD buffer byte pairs into save RAM words on load, splits
// words back into bytes on save, steps the word address
//====================================================================

module bk_word_packer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  xfer_start,
	input  sd_pkg::sd_buf_addr_t  sd_buff_addr,
	input  sd_pkg::sd_byte_t      sd_buff_dout,
	input  logic                  sd_buff_wr,
	input  logic                  sd_buff_rd,
	input  bk_pkg::bk_word_t      word_rdata,
	output sd_pkg::sd_byte_t      sd_buff_din,
	output bk_pkg::bk_word_addr_t word_addr,
	output bk_pkg::bk_word_t      word_wdata,
	output logic                  word_we
);

	sd_pkg::sd_byte_t lo_byte;
	bk_pkg::bk_word_t rd_word;
	logic             byte_hi;

	// Odd index is the upper byte of the word
	assign byte_hi = sd_buff_addr[0];

	// ==================================================================
	// Word address
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			word_addr <= '0;
		end else if (xfer_start) begin
			word_addr <= '0;
		end else if ((sd_buff_wr | sd_buff_rd) & byte_hi) begin
			word_addr <= word_addr + 1'b1;
		end
	end

	// ==================================================================
	// Load path
	// ==================================================================

	// Word written on the upper byte strobe, same edge as the step
	assign word_we    = sd_buff_wr & byte_hi;
	assign word_wdata = {sd_buff_dout, lo_byte};

	always_ff @(posedge clk_sys) begin
		if (sd_buff_wr && !byte_hi) begin
			lo_byte <= sd_buff_dout;
		end
	end

	// ==================================================================
	// Save path
	// ==================================================================

	// Hold the word through the odd index that follows
	always_ff @(posedge clk_sys) begin
		if (!byte_hi) begin
			rd_word <= word_rdata;
		end
	end

	assign sd_buff_din = byte_hi ? rd_word[15:8] : rd_word[7:0];

	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_buff_wr && sd_buff_rd));

endmodule

`default_nettype wire

// ==== hw/bk_save_ram.sv ====
`default_nettype none

//====================================================================
// Save RAM
// Word port for the backup engine, byte port for the console
//====================================================================

module bk_save_ram (
	input  logic                  clk_sys,
	input  bk_pkg::bk_word_addr_t word_addr,
	input  bk_pkg::bk_word_t      word_wdata,
	input  logic                  word_we,
	input  bk_pkg::bk_byte_addr_t bsram_addr,
	input  sd_pkg::sd_byte_t      bsram_din,
	input  logic                  bsram_we,
	output bk_pkg::bk_word_t      word_rdata,
	output sd_pkg::sd_byte_t      bsram_dout
);

	bk_pkg::bk_word_t      mem [bk_pkg::BK_WORDS];
	bk_pkg::bk_word_addr_t bs_word;
	logic                  bs_lane;

	// Even byte address is the low byte of the word
	assign bs_word = bsram_addr[bk_pkg::BK_WORD_ADDR_W:1];
	assign bs_lane = bsram_addr[0];

	always_ff @(posedge clk_sys) begin
		// Backup word port
		if (word_we) begin
			mem[word_addr] <= word_wdata;
		end
		word_rdata <= mem[word_addr];

		// Console byte port
		if (bsram_we) begin
			mem[bs_word][8*bs_lane +: 8] <= bsram_din;
		end
		bsram_dout <= mem[bs_word][8*bs_lane +: 8];
	end

endmodule

`default_nettype wire

// ==== hw/bk_backup_top.sv ====
`default_nettype none

//====================================================================
// Save RAM backup engine
// Loads a mounted save image into save RAM and writes it back to
// the SD card on request
//====================================================================

module bk_backup_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  img_mounted,
	input  sd_pkg::sd_size_t      img_size,
	input  logic                  cart_download,
	input  logic                  save_req,
	output sd_pkg::sd_lba_t       sd_lba,
	output logic                  sd_rd,
	output logic                  sd_wr,
	input  logic                  sd_ack,
	input  sd_pkg::sd_buf_addr_t  sd_buff_addr,
	input  sd_pkg::sd_byte_t      sd_buff_dout,
	output sd_pkg::sd_byte_t      sd_buff_din,
	input  logic                  sd_buff_wr,
	input  logic                  sd_buff_rd,
	input  bk_pkg::bk_byte_addr_t bsram_addr,
	input  sd_pkg::sd_byte_t      bsram_din,
	input  logic                  bsram_we,
	output sd_pkg::sd_byte_t      bsram_dout,
	output logic                  bk_ena,
	output logic                  bk_busy
);

	logic                  xfer_start;
	logic                  sector_step;
	logic                  last_sector;
	bk_pkg::bk_sector_t    last_lba;
	bk_pkg::bk_word_addr_t word_addr;
	bk_pkg::bk_word_t      word_wdata;
	bk_pkg::bk_word_t      word_rdata;
	logic                  word_we;

	bk_control_fsm u_fsm (
		.clk_sys(clk_sys), .reset(reset),
		.img_mounted(img_mounted), .img_size(img_size),
		.cart_download(cart_download), .save_req(save_req),
		.sd_ack(sd_ack), .last_sector(last_sector),
		.bk_ena(bk_ena), .bk_busy(bk_busy),
		.sd_rd(sd_rd), .sd_wr(sd_wr),
		.xfer_start(xfer_start), .sector_step(sector_step),
		.last_lba(last_lba)
	);

	bk_sector_counter u_counter (
		.clk_sys(clk_sys), .reset(reset),
		.xfer_start(xfer_start), .sector_step(sector_step),
		.last_lba(last_lba),
		.sd_lba(sd_lba), .last_sector(last_sector)
	);

	bk_word_packer u_packer (
		.clk_sys(clk_sys), .reset(reset), .xfer_start(xfer_start),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_buff_rd(sd_buff_rd),
		.word_rdata(word_rdata), .sd_buff_din(sd_buff_din),
		.word_addr(word_addr), .word_wdata(word_wdata), .word_we(word_we)
	);

	bk_save_ram u_ram (
		.clk_sys(clk_sys),
		.word_addr(word_addr), .word_wdata(word_wdata), .word_we(word_we),
		.bsram_addr(bsram_addr), .bsram_din(bsram_din), .bsram_we(bsram_we),
		.word_rdata(word_rdata), .bsram_dout(bsram_dout)
	);

endmodule

`default_nettype wire

// ==== dv/bk_tb_tasks.svh ====
//======================================================================
// Backup engine test tasks
// Typed compare tasks, bus helpers and directed tests
//======================================================================

`ifndef BK_TB_TASKS_SVH
`define BK_TB_TASKS_SVH

task automatic compare_byte(input string name, input sd_pkg::sd_byte_t got,
		input sd_pkg::sd_byte_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic compare_lba(input string name, input sd_pkg::sd_lba_t got,
		input sd_pkg::sd_lba_t exp);
	if (got !== exp) begin
		$display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic wait_idle();
	int n;
	n = 0;
	while (bk_busy && n < IDLE_TIMEOUT) begin
		@(posedge clk_sys);
		#1;
		n++;
	end
	if (bk_busy) begin
		$display("Timeout: bk_busy stayed high after the last sector");
		timeout_count++;
	end
	compare_flag("sd_rd", sd_rd, 1'b0);
	compare_flag("sd_wr", sd_wr, 1'b0);
endtask

// No request may show up within the window
task automatic expect_quiet();
	for (int n = 0; n < QUIET_CYCLES; n++) begin
		@(posedge clk_sys);
		#1;
		if (sd_rd || sd_wr || bk_busy) begin
			$display("SD request raised while the engine should stay idle");
			error_count++;
			return;
		end
	end
endtask

task automatic mount_image(input sd_pkg::sd_size_t size);
	img_size    = size;
	img_mounted = 1'b1;
	@(posedge clk_sys);
	#1;
	img_mounted = 1'b0;
endtask

task automatic pulse_save();
	save_req = 1'b1;
	@(posedge clk_sys);
	#1;
	save_req = 1'b0;
endtask

task automatic console_write(input bk_pkg::bk_byte_addr_t addr, input sd_pkg::sd_byte_t data);
	bsram_addr = addr;
	bsram_din  = data;
	bsram_we   = 1'b1;
	@(posedge clk_sys);
	#1;
	bsram_we = 1'b0;
endtask

task automatic console_read(input bk_pkg::bk_byte_addr_t addr, output sd_pkg::sd_byte_t data);
	bsram_addr = addr;
	@(posedge clk_sys);
	#1;
	data = bsram_dout;
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic reset_defaults();
	compare_flag("sd_rd", sd_rd, 1'b0);
	compare_flag("sd_wr", sd_wr, 1'b0);
	compare_flag("bk_ena", bk_ena, 1'b0);
	compare_flag("bk_busy", bk_busy, 1'b0);
	pulse_save();
	expect_quiet();
endtask

task automatic zero_mount();
	mount_image('0);
	compare_flag("bk_ena", bk_ena, 1'b0);
	expect_quiet();
endtask

task automatic load_image();
	bk_pkg::bk_byte_addr_t ba;
	sd_pkg::sd_byte_t      got;
	mount_image(sd_pkg::sd_size_t'(LOAD_SECTORS * sd_pkg::SECTOR_BYTES));
	compare_flag("bk_ena", bk_ena, 1'b1);
	for (int s = 0; s < LOAD_SECTORS; s++) begin
		serve_sector(1'b1, s);
	end
	wait_idle();
	for (int a = 0; a < LOAD_SECTORS * sd_pkg::SECTOR_BYTES; a++) begin
		ba = bk_pkg::bk_byte_addr_t'(a);
		console_read(ba, got);
		compare_byte("bsram_dout", got, ref_mem[ba]);
	end
endtask

task automatic edit_and_save();
	int                    edits [6] = '{0, 1, 100, 513, 1022, 2047};
	bk_pkg::bk_byte_addr_t ba;
	sd_pkg::sd_byte_t      b;
	foreach (edits[i]) begin
		ba = bk_pkg::bk_byte_addr_t'(edits[i]);
		draw_byte(b);
		console_write(ba, b);
		ref_mem[ba] = b;
	end
	pulse_save();
	for (int s = 0; s < LOAD_SECTORS; s++) begin
		serve_sector(1'b0, s);
	end
	wait_idle();
endtask

task automatic download_disables();
	cart_download = 1'b1;
	repeat (2) begin
		@(posedge clk_sys);
		#1;
	end
	compare_flag("bk_ena", bk_ena, 1'b0);
	cart_download = 1'b0;
	pulse_save();
	expect_quiet();
endtask

`endif

// ==== dv/bk_tb.sv ====
`default_nettype none

//======================================================================
// Backup engine testbench
// Clock, reset, SD host model, LFSR data source and test sequence
//======================================================================

module bk_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LOAD_SECTORS = 4;
	localparam int REQ_TIMEOUT  = 64;
	localparam int IDLE_TIMEOUT = 64;
	localparam int QUIET_CYCLES = 40;
	localparam int RUN_LIMIT    = 200000;

	logic                  clk_sys;
	logic                  reset;
	logic                  img_mounted;
	sd_pkg::sd_size_t      img_size;
	logic                  cart_download;
	logic                  save_req;
	sd_pkg::sd_lba_t       sd_lba;
	logic                  sd_rd;
	logic                  sd_wr;
	logic                  sd_ack;
	sd_pkg::sd_buf_addr_t  sd_buff_addr;
	sd_pkg::sd_byte_t      sd_buff_dout;
	sd_pkg::sd_byte_t      sd_buff_din;
	logic                  sd_buff_wr;
	logic                  sd_buff_rd;
	bk_pkg::bk_byte_addr_t bsram_addr;
	sd_pkg::sd_byte_t      bsram_din;
	logic                  bsram_we;
	sd_pkg::sd_byte_t      bsram_dout;
	logic                  bk_ena;
	logic                  bk_busy;

	// Expected save RAM contents by byte address
	sd_pkg::sd_byte_t ref_mem [2 * bk_pkg::BK_WORDS];
	logic [15:0]      lfsr_state;
	int               error_count;
	int               timeout_count;

	bk_backup_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Galois LFSR with taps for a maximal 16 bit sequence
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_byte(output sd_pkg::sd_byte_t b);
		b = '0;
		for (int k = 0; k < 8; k++) begin
			b = {lfsr_state[0], b[7:1]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// ==================================================================
	// SD host model serving one sector per call
	// ==================================================================

	task automatic serve_sector(input logic load, input int exp_lba);
		int                    n;
		int                    base;
		bk_pkg::bk_byte_addr_t ba;
		sd_pkg::sd_byte_t      b;
		n = 0;
		while (!(sd_rd || sd_wr) && n < REQ_TIMEOUT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (!(sd_rd || sd_wr)) begin
			$display("Timeout: no SD request for sector %0d", exp_lba);
			timeout_count++;
			return;
		end
		compare_flag("sd_rd", sd_rd, load);
		compare_flag("sd_wr", sd_wr, ~load);
		compare_flag("bk_busy", bk_busy, 1'b1);
		compare_lba("sd_lba", sd_lba, sd_pkg::sd_lba_t'(exp_lba));
		sd_ack = 1'b1;
		base = exp_lba * sd_pkg::SECTOR_BYTES;
		for (int i = 0; i < sd_pkg::SECTOR_BYTES; i++) begin
			ba = bk_pkg::bk_byte_addr_t'(base + i);
			sd_buff_addr = sd_pkg::sd_buf_addr_t'(i);
			if (load) begin
				draw_byte(b);
				sd_buff_dout = b;
				ref_mem[ba] = b;
			end
			// Address held 3 cycles before sample and strobe
			repeat (3) @(posedge clk_sys);
			#1;
			if (load) begin
				sd_buff_wr = 1'b1;
			end else begin
				compare_byte("sd_buff_din", sd_buff_din, ref_mem[ba]);
				sd_buff_rd = 1'b1;
			end
			@(posedge clk_sys);
			#1;
			sd_buff_wr = 1'b0;
			sd_buff_rd = 1'b0;
		end
		compare_flag("sd_rd", sd_rd, 1'b0);
		compare_flag("sd_wr", sd_wr, 1'b0);
		sd_ack = 1'b0;
	endtask

	`include "bk_tb_tasks.svh"

	initial begin
		repeat (RUN_LIMIT) @(posedge clk_sys);
		$display("Run limit reached before the test sequence finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		reset         = 1'b1;
		img_mounted   = 1'b0;
		img_size      = '0;
		cart_download = 1'b0;
		save_req      = 1'b0;
		sd_ack        = 1'b0;
		sd_buff_addr  = '0;
		sd_buff_dout  = '0;
		sd_buff_wr    = 1'b0;
		sd_buff_rd    = 1'b0;
		bsram_addr    = '0;
		bsram_din     = '0;
		bsram_we      = 1'b0;
		lfsr_state    = 16'd7137;
		error_count   = 0;
		timeout_count = 0;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		reset_defaults();
		zero_mount();
		load_image();
		edit_and_save();
		download_disables();

		$display("Checks done: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
hw/sd_pkg.sv
hw/bk_pkg.sv
hw/bk_control_fsm.sv
hw/bk_sector_counter.sv
hw/bk_word_packer.sv
hw/bk_save_ram.sv
hw/bk_backup_top.sv
dv/bk_tb.sv

// ==== Makefile ====
# Verilator build for the save RAM backup engine

VERILATOR ?= verilator
TOP       ?= bk_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
